//--- Bender.yml
package:
  name: core

sources:
  - include_dirs:
      - src
    files:
      - src/core_pkg.sv
      - src/fetch.sv
      - src/register_file.sv
      - src/decode.sv
      - src/alu_unit.sv
      - src/core.sv
  - target: test
    include_dirs:
      - src
      - test
    files:
      - test/tb_core.sv

//--- core.f
+incdir+src
+incdir+test
src/core_pkg.sv
src/fetch.sv
src/register_file.sv
src/decode.sv
src/alu_unit.sv
src/core.sv
test/tb_core.sv

//--- src/alu_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU and the writeback register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module alu_unit (
        input logic clk,
        input logic rst_n,

        // Issue register
        input logic is_valid,
        input logic is_illegal,
        input core_pkg::word_t is_pc,
        input core_pkg::reg_addr_t is_rd,
        input core_pkg::alu_op_t is_op,
        input core_pkg::word_t is_a,
        input core_pkg::word_t is_b,

        // Forwarding back to decode
        output logic ex_valid,
        output core_pkg::reg_addr_t ex_rd,
        output core_pkg::word_t ex_result,

        // Writeback and retire
        output logic wb_valid,
        output core_pkg::reg_addr_t wb_rd,
        output core_pkg::word_t wb_data,
        output core_pkg::word_t wb_pc,
        output logic illegal_instruction
        );

    logic [4:0] shamt;

    assign shamt = is_b[4:0];

    always_comb begin
        case (is_op)
            core_pkg::ADD: ex_result = is_a + is_b;
            core_pkg::SUB: ex_result = is_a - is_b;
            core_pkg::SLL: ex_result = is_a << shamt;
            core_pkg::SLT: ex_result = {31'b0, $signed(is_a) < $signed(is_b)};
            core_pkg::SLTU: ex_result = {31'b0, is_a < is_b};
            core_pkg::XOR: ex_result = is_a ^ is_b;
            core_pkg::SRL: ex_result = is_a >> shamt;
            // Sign bit fills from the left
            core_pkg::SRA: ex_result = $signed(is_a) >>> shamt;
            core_pkg::OR: ex_result = is_a | is_b;
            core_pkg::AND: ex_result = is_a & is_b;
            default: ex_result = is_b;
        endcase
    end

    // Only a legal instruction may be forwarded
    assign ex_valid = is_valid && !is_illegal;
    assign ex_rd = is_rd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            illegal_instruction <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            illegal_instruction <= is_valid && is_illegal;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd <= is_rd;
        wb_data <= ex_result;
        wb_pc <= is_pc;
    end

    alu_retire_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_valid && illegal_instruction))
        else $error("Writeback and illegal pulse in the same slot");

endmodule

//--- src/core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the in-order integer core
// RAM port, decode taps and retire ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "core_consts.svh"

module core (
        input logic clk,
        input logic rst_n,

        // Instruction RAM
        output logic instr_en,
        output logic [`CORE_IMEM_ADDR_W-1:0] instr_addr,
        input core_pkg::word_t instr_data,

        // Decode stage debug taps
        output core_pkg::word_t dec_pc_debug,
        output core_pkg::word_t dec_instruction,
        output logic dec_advance_debug,

        // Retire
        output logic wb_valid,
        output core_pkg::reg_addr_t wb_rd,
        output core_pkg::word_t wb_data,
        output core_pkg::word_t wb_pc,
        output logic illegal_instruction
        );

    // Fetch to decode
    logic if_valid;
    core_pkg::word_t if_pc;
    core_pkg::word_t if_instr;

    // Issue register
    logic is_valid;
    logic is_illegal;
    core_pkg::word_t is_pc;
    core_pkg::reg_addr_t is_rd;
    core_pkg::alu_op_t is_op;
    core_pkg::word_t is_a;
    core_pkg::word_t is_b;

    // Execute forwarding
    logic ex_valid;
    core_pkg::reg_addr_t ex_rd;
    core_pkg::word_t ex_result;

    assign dec_pc_debug = if_pc;
    assign dec_instruction = if_instr;
    assign dec_advance_debug = if_valid;

    fetch fetch_block (.*);

    decode decode_block (.*);

    alu_unit alu_unit_block (.*);

endmodule

//--- src/core_consts.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core build constants, included by the
// modules that size or start the fetch path
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Byte address of the first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

// Word address width of the instruction RAM
// 1024 words of program space
`define CORE_IMEM_ADDR_W 10

`endif

//--- src/core_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the integer core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package core_pkg;

    // Data word, instruction word or PC
    typedef logic [31:0] word_t;

    // Architectural register index
    typedef logic [4:0] reg_addr_t;

    // Major opcodes handled by the core
    // Anything else decodes as illegal
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_t;

    // ALU operations
    // Encoded as {funct7[5], funct3} so decode can build them directly
    // PASS_B takes the U-type immediate for LUI
    typedef enum logic [3:0] {
        ADD    = 4'b0000,
        SLL    = 4'b0001,
        SLT    = 4'b0010,
        SLTU   = 4'b0011,
        XOR    = 4'b0100,
        SRL    = 4'b0101,
        OR     = 4'b0110,
        AND    = 4'b0111,
        SUB    = 4'b1000,
        SRA    = 4'b1101,
        PASS_B = 4'b1111
    } alu_op_t;

endpackage

//--- src/decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode and issue, with operand read and
// forwarding from the execute stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module decode (
        input logic clk,
        input logic rst_n,

        // From fetch
        input logic if_valid,
        input core_pkg::word_t if_pc,
        input core_pkg::word_t if_instr,

        // Execute stage result for forwarding
        input logic ex_valid,
        input core_pkg::reg_addr_t ex_rd,
        input core_pkg::word_t ex_result,

        // Writeback into the register file
        input logic wb_valid,
        input core_pkg::reg_addr_t wb_rd,
        input core_pkg::word_t wb_data,

        // Issue register
        output logic is_valid,
        output logic is_illegal,
        output core_pkg::word_t is_pc,
        output core_pkg::reg_addr_t is_rd,
        output core_pkg::alu_op_t is_op,
        output core_pkg::word_t is_a,
        output core_pkg::word_t is_b
        );

    core_pkg::opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    core_pkg::word_t imm_i;
    core_pkg::word_t imm_u;
    core_pkg::word_t rs1_data;
    core_pkg::word_t rs2_data;
    core_pkg::word_t src_a;
    core_pkg::word_t src_b;
    core_pkg::alu_op_t op;
    logic illegal;

    // Instruction fields
    assign opcode = core_pkg::opcode_t'(if_instr[6:0]);
    assign funct3 = if_instr[14:12];
    assign funct7 = if_instr[31:25];
    assign rs1 = if_instr[19:15];
    assign rs2 = if_instr[24:20];
    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_u = {if_instr[31:12], 12'b0};

    register_file register_file_block (
        .clk, .rst_n,
        .rs1, .rs2, .rs1_data, .rs2_data,
        .wb_valid, .wb_rd, .wb_data
    );

    // Younger result in execute wins over the register file
    assign src_a = (ex_valid && ex_rd != '0 && ex_rd == rs1) ? ex_result : rs1_data;
    assign src_b = (ex_valid && ex_rd != '0 && ex_rd == rs2) ? ex_result : rs2_data;

    // Operation select and legality
    always_comb begin
        op = core_pkg::alu_op_t'({1'b0, funct3});
        illegal = 1'b0;
        case (opcode)
            core_pkg::OP: begin
                op = core_pkg::alu_op_t'({funct7[5], funct3});
                // Alternate form only for SUB and SRA
                if (funct7 == 7'b0100000)
                    illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
                else
                    illegal = (funct7 != 7'b0000000);
            end
            core_pkg::OP_IMM: begin
                // Shift immediates carry funct7 in the upper imm bits
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    op = core_pkg::alu_op_t'({funct7[5], funct3});
                    illegal = !(funct7 == 7'b0000000 || funct7 == 7'b0100000);
                end
            end
            core_pkg::LUI: op = core_pkg::PASS_B;
            default: illegal = 1'b1;
        endcase
    end

    // Issue register control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            is_valid <= 1'b0;
            is_illegal <= 1'b0;
        end else begin
            is_valid <= if_valid;
            is_illegal <= if_valid && illegal;
        end
    end

    // Issue register payload
    always_ff @(posedge clk) begin
        is_pc <= if_pc;
        is_rd <= if_instr[11:7];
        is_op <= op;
        is_a <= src_a;
        // B is rs2 for OP, otherwise the immediate
        if (opcode == core_pkg::OP)
            is_b <= src_b;
        else if (opcode == core_pkg::LUI)
            is_b <= imm_u;
        else
            is_b <= imm_i;
    end

    dec_illegal_valid : assert property (@(posedge clk) disable iff (!rst_n)
        is_illegal |-> is_valid)
        else $error("Illegal flag issued without a valid instruction");

endmodule

//--- src/fetch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage, one word per cycle from a
// fixed one-cycle-latency instruction RAM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "core_consts.svh"

module fetch (
        input logic clk,
        input logic rst_n,

        // Instruction RAM port
        output logic instr_en,
        output logic [`CORE_IMEM_ADDR_W-1:0] instr_addr,
        input core_pkg::word_t instr_data,

        // To decode
        output logic if_valid,
        output core_pkg::word_t if_pc,
        output core_pkg::word_t if_instr
        );

    core_pkg::word_t pc;
    core_pkg::word_t pc_req;
    logic req_pending;

    // Word address of the current PC
    assign instr_addr = pc[`CORE_IMEM_ADDR_W+1:2];

    // PC moves on every sampled request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `CORE_RESET_PC;
            instr_en <= 1'b0;
            req_pending <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            instr_en <= 1'b1;
            if (instr_en)
                pc <= pc + 32'd4;
            // RAM answers in the cycle after the request is sampled
            req_pending <= instr_en;
            if_valid <= req_pending;
        end
    end

    // PC of each request, held until its word comes back
    always_ff @(posedge clk) begin
        pc_req <= pc;
        if_pc <= pc_req;
        if_instr <= instr_data;
    end

    // Sequential request stream, no gaps once started
    fetch_addr_seq : assert property (@(posedge clk) disable iff (!rst_n)
        instr_en && $past(instr_en) |-> instr_addr == $past(instr_addr) + 1'b1)
        else $error("Fetch request address did not advance by one word");

endmodule

//--- src/register_file.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 integer register file with
// write-through to both read ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module register_file (
        input logic clk,
        input logic rst_n,

        // Read ports, combinational
        input core_pkg::reg_addr_t rs1,
        input core_pkg::reg_addr_t rs2,
        output core_pkg::word_t rs1_data,
        output core_pkg::word_t rs2_data,

        // Write port from writeback
        input logic wb_valid,
        input core_pkg::reg_addr_t wb_rd,
        input core_pkg::word_t wb_data
        );

    core_pkg::word_t regs [32];
    logic wb_write;

    // x0 is never written
    assign wb_write = wb_valid && (wb_rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle write is seen by the reader
    assign rs1_data = (wb_write && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (wb_write && wb_rd == rs2) ? wb_data : regs[rs2];

    // x0 reads as zero whatever was retired to it
    rf_x0_zero : assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == '0 |-> rs1_data == '0) and (rs2 == '0 |-> rs2_data == '0))
        else $error("Register x0 read back nonzero");

endmodule

//--- test/core_ref_model.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program generator and in-order reference model,
// included inside the core testbench module
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// One expected retire slot
typedef struct {
    core_pkg::word_t pc;
    logic illegal;
    core_pkg::reg_addr_t rd;
    core_pkg::word_t data;
} retire_t;

core_pkg::word_t program_mem [1024];
retire_t expected [$];
integer seed;

// Source register, mostly one of the last two destinations
function automatic core_pkg::reg_addr_t pick_src(input core_pkg::reg_addr_t near0,
                                                  input core_pkg::reg_addr_t near1);
    int unsigned sel;
    sel = $unsigned($random(seed)) % 4;
    if (sel == 0)
        return near0;
    if (sel == 1)
        return near1;
    return core_pkg::reg_addr_t'($random(seed));
endfunction

// Fill the whole program, about 10% illegal words
function automatic void gen_program();
    core_pkg::reg_addr_t last [2];
    int unsigned kind;
    logic [2:0] f3;
    logic [6:0] f7;
    core_pkg::word_t w;
    last[0] = '0;
    last[1] = '0;
    for (int i = 0; i < 1024; i++) begin
        kind = $unsigned($random(seed)) % 20;
        f3 = 3'($random(seed));
        // w also supplies rd and the immediates
        w = $random(seed);
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'h20 : 7'h00;
        if (kind < 2) begin
            // Custom-0 opcode or an M-extension funct7
            if (w[0])
                w = {w[31:7], 7'b0001011};
            else
                w = {7'h01, w[24:7], 7'b0110011};
        end else if (kind < 9) begin
            w = {f7, pick_src(last[0], last[1]), pick_src(last[0], last[1]),
                 f3, w[11:7], 7'b0110011};
        end else if (kind < 16) begin
            // Shift immediates need a clean funct7
            if (f3 == 3'd1)
                w[31:25] = 7'h00;
            else if (f3 == 3'd5)
                w[31:25] = f7;
            w = {w[31:20], pick_src(last[0], last[1]), f3, w[11:7], 7'b0010011};
        end else begin
            w = {w[31:7], 7'b0110111};
        end
        last[1] = last[0];
        last[0] = w[11:7];
        program_mem[i] = w;
    end
endfunction

// Architectural execution, one retire slot per word
function automatic void run_model();
    core_pkg::word_t regs [32];
    core_pkg::word_t w;
    core_pkg::word_t a;
    core_pkg::word_t b;
    core_pkg::word_t val;
    logic legal;
    logic alt;
    retire_t ev;
    foreach (regs[r])
        regs[r] = '0;
    for (int i = 0; i < 1024; i++) begin
        w = program_mem[i];
        a = regs[w[19:15]];
        b = (w[6:0] == 7'b0110011) ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        alt = w[30];
        val = '0;
        case (w[6:0])
            7'b0110111: legal = 1'b1;
            7'b0110011: legal = (w[31:25] == 7'h00) ||
                                (w[31:25] == 7'h20 && (w[14:12] == 3'd0 || w[14:12] == 3'd5));
            7'b0010011: begin
                if (w[14:12] == 3'd1)
                    legal = (w[31:25] == 7'h00);
                else if (w[14:12] == 3'd5)
                    legal = (w[31:25] == 7'h00 || w[31:25] == 7'h20);
                else
                    legal = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        if (w[6:0] == 7'b0110111) begin
            val = {w[31:12], 12'b0};
        end else begin
            // Bit 5 of the opcode tells register form from immediate form
            case (w[14:12])
                3'd0: val = (w[5] && alt) ? a - b : a + b;
                3'd1: val = a << b[4:0];
                3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: val = (a < b) ? 32'd1 : 32'd0;
                3'd4: val = a ^ b;
                3'd5: begin
                    if (alt)
                        val = $signed(a) >>> b[4:0];
                    else
                        val = a >> b[4:0];
                end
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end
        ev.pc = `CORE_RESET_PC + i * 4;
        ev.illegal = !legal;
        ev.rd = w[11:7];
        ev.data = val;
        expected.push_back(ev);
        // Illegal words and x0 leave the state alone
        if (legal && w[11:7] != 5'd0)
            regs[w[11:7]] = val;
    end
endfunction

`endif

//--- test/tb_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random-program testbench for the core
// against the in-order reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "core_consts.svh"

module tb_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RETIRE_TARGET = 1000;

    logic clk = 1'b0;
    logic rst_n;
    logic instr_en;
    logic [`CORE_IMEM_ADDR_W-1:0] instr_addr;
    core_pkg::word_t instr_data;
    core_pkg::word_t dec_pc_debug;
    core_pkg::word_t dec_instruction;
    logic dec_advance_debug;
    logic wb_valid;
    core_pkg::reg_addr_t wb_rd;
    core_pkg::word_t wb_data;
    core_pkg::word_t wb_pc;
    logic illegal_instruction;

    // RAM model state
    logic [`CORE_IMEM_ADDR_W-1:0] addr_q;
    logic req_q = 1'b0;
    logic req_seen = 1'b0;
    int requested = 0;
    int decoded = 0;
    int retired = 0;

    `include "core_ref_model.svh"

    core uut (.*);

    always #4 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp)
            report_failure($sformatf("FAIL at %0d ns: %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic check_reg(input string name, input core_pkg::reg_addr_t got,
                             input core_pkg::reg_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("FAIL at %0d ns: %s got %0d expected %0d",
                                     $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("FAIL at %0d ns: %s got %b expected %b",
                                     $time, name, got, exp));
    endtask

    // RAM samples the request on the rising edge
    always @(posedge clk) begin
        req_q <= instr_en;
        addr_q <= instr_addr;
    end

    // and answers on the falling edge, half a cycle before fetch captures it
    always @(negedge clk) begin
        if (req_q)
            instr_data <= program_mem[addr_q];
    end

    // Request, decode and retire monitor, outputs are stable at the falling edge
    always @(negedge clk) begin
        retire_t ev;
        if (rst_n === 1'b1) begin
            // Once started, fetch asks for the next word every cycle
            if (req_seen)
                check_flag("instr_en", instr_en, 1'b1);
            if (instr_en) begin
                check_word("instr_addr", core_pkg::word_t'(instr_addr),
                           (`CORE_RESET_PC >> 2) + requested);
                requested++;
                req_seen = 1'b1;
            end
            // Decode taps follow program order with no gaps
            if (dec_advance_debug) begin
                check_word("dec_pc_debug", dec_pc_debug, `CORE_RESET_PC + decoded * 4);
                check_word("dec_instruction", dec_instruction, program_mem[decoded]);
                decoded++;
            end else if (decoded > 0 && retired < RETIRE_TARGET) begin
                report_failure("Decode stage had a gap after the first instruction");
            end
            if (wb_valid || illegal_instruction) begin
                if (expected.size() == 0)
                    report_failure("Core retired more instructions than the program holds");
                ev = expected.pop_front();
                check_word("wb_pc", wb_pc, ev.pc);
                check_flag("illegal_instruction", illegal_instruction, ev.illegal);
                check_flag("wb_valid", wb_valid, !ev.illegal);
                // Destination and data only matter for a real writeback
                if (!ev.illegal) begin
                    check_reg("wb_rd", wb_rd, ev.rd);
                    check_word("wb_data", wb_data, ev.data);
                end
                retired++;
            end else if (retired > 0 && retired < RETIRE_TARGET) begin
                report_failure("Retire stream had a gap after the pipeline filled");
            end
        end
    end

    // Run length plus reset and pipeline fill
    initial begin
        #((1024 + 10 + 20) * 8);
        report_failure("Watchdog expired before all instructions retired");
    end

    initial begin
        rst_n = 1'b0;
        instr_data = '0;
        seed = 63486;
        gen_program();
        run_model();
        repeat (10) begin
            @(negedge clk);
            check_flag("wb_valid", wb_valid, 1'b0);
            check_flag("illegal_instruction", illegal_instruction, 1'b0);
            check_flag("dec_advance_debug", dec_advance_debug, 1'b0);
        end
        rst_n = 1'b1;
        // Pipeline still empty one cycle later
        @(negedge clk);
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("illegal_instruction", illegal_instruction, 1'b0);
        check_flag("dec_advance_debug", dec_advance_debug, 1'b0);
        wait (retired == RETIRE_TARGET);
        $display("No errors");
        $finish;
    end

endmodule
